// File: common/fdiv_pkg.sv
`default_nettype none

package fdiv_pkg;

    // Operand and result widths.
    localparam int MANT_W    = 53;   // Significand with hidden bit.
    localparam int OP_W      = 58;   // Multiplier operand, 5 guard bits.
    localparam int PROD_W    = 116;
    localparam int Q_W       = 57;   // Quotient plus sticky.

    // Quotient bits dropped in single precision.
    localparam int SP_ZERO_W = 29;

    // Newton-Raphson iteration counts.
    localparam int ITER_DP   = 3;
    localparam int ITER_SP   = 2;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_SEED,
        ST_NR_MUL1,     // Operands x, fb.
        ST_NR_CPL,      // 2 - fb*x.
        ST_NR_MUL2,     // Operands cpl, x.
        ST_NR_UPD,
        ST_Q_MUL,
        ST_Q_EST,
        ST_Q_CHK,
        ST_RESULT
    } div_state_t;

endpackage

`default_nettype wire

// File: common/quot_if.sv
`default_nettype none

interface quot_if;
    import fdiv_pkg::*;

    logic [Q_W-2:0]          q_est;   // Estimate, 55 fraction bits.
    logic [MANT_W+Q_W-2:0]   q_b;     // q_est * den.
    logic [MANT_W-1:0]       num;
    logic [MANT_W-1:0]       den;
    logic                    sp;
    logic [Q_W-1:0]          q_fin;

    modport ctrl (
        output q_est, q_b, num, den, sp,
        input  q_fin
    );

    modport sel (
        input  q_est, q_b, num, den, sp,
        output q_fin
    );

endinterface

`default_nettype wire

// File: rtl/recip_rom.sv
`default_nettype none

module recip_rom (
    input  logic [7:0] addr,
    output logic [7:0] data
);

    // Entry i is round(2^9 / (1 + (i + 0.5)/256)) with the leading one removed.
    // That value is 2^18 / (513 + 2i), always in 256..511.
    function automatic logic [255:0][7:0] build_table();
        logic [255:0][7:0] tbl;
        int                den;
        int                quo;
        for (int i = 0; i < 256; i++) begin
            den    = 513 + 2 * i;
            quo    = (2 * 262144 + den) / (2 * den);   // Round to nearest.
            tbl[i] = 8'(quo - 256);
        end
        return tbl;
    endfunction

    localparam logic [255:0][7:0] SEED_TBL = build_table();

    assign data = SEED_TBL[addr];

endmodule

`default_nettype wire

// File: rtl/mant_mul.sv
`default_nettype none

module mant_mul (
    input  logic [fdiv_pkg::OP_W-1:0]   a,
    input  logic [fdiv_pkg::OP_W-1:0]   b,
    output logic [fdiv_pkg::PROD_W-1:0] p
);
    import fdiv_pkg::*;

    localparam int NPP = (OP_W + 2) / 2;   // 30 Booth digits.

    logic [OP_W+2:0]   b_ext;
    logic [PROD_W-1:0] a_ext;
    logic [PROD_W-1:0] pp [NPP];

    // Two zero bits on top keep the unsigned multiplier positive.
    assign b_ext = {2'b00, b, 1'b0};
    assign a_ext = {{(PROD_W-OP_W){1'b0}}, a};

    // Radix-4 recoding, negative terms in two's complement mod 2^116.
    always_comb begin
        for (int i = 0; i < NPP; i++) begin
            case (b_ext[2*i +: 3])
                3'b001, 3'b010: pp[i] = a_ext;
                3'b011:         pp[i] = a_ext << 1;
                3'b100:         pp[i] = -(a_ext << 1);
                3'b101, 3'b110: pp[i] = -a_ext;
                default:        pp[i] = '0;
            endcase
            pp[i] = pp[i] << (2 * i);
        end
    end

    always_comb begin
        logic [PROD_W-1:0] acc;
        acc = '0;
        for (int i = 0; i < NPP; i++) begin
            acc = acc + pp[i];
        end
        p = acc;
    end

endmodule

`default_nettype wire

// File: rtl/quot_select.sv
`default_nettype none

module quot_select (
    quot_if.sel q
);
    import fdiv_pkg::*;

    localparam int R_W = MANT_W + Q_W + 1;   // Signed remainder, 111 bits.

    localparam logic [Q_W-2:0] ULP_DP = 1;
    localparam logic [Q_W-2:0] ULP_SP = ULP_DP << SP_ZERO_W;

    logic [R_W-1:0] rem;
    logic [R_W-1:0] rem_adj;
    logic [R_W-1:0] den_ulp;
    logic [Q_W-2:0] ulp;
    logic [Q_W-2:0] q_adj;
    logic           rem_neg;
    logic           rem_big;
    logic           sticky;

    // One unit of the selected precision and the divisor scaled to it.
    assign ulp     = q.sp ? ULP_SP : ULP_DP;
    assign den_ulp = q.sp ? {{(R_W-MANT_W-SP_ZERO_W){1'b0}}, q.den, {SP_ZERO_W{1'b0}}}
                          : {{(R_W-MANT_W){1'b0}}, q.den};

    // fa * 2^55 - q_est * fb.
    assign rem = {3'b000, q.num, {(Q_W-2){1'b0}}} - {2'b00, q.q_b};

    assign rem_neg = rem[R_W-1];
    assign rem_big = !rem_neg && (rem >= den_ulp);

    always_comb begin
        if (rem_neg) begin
            q_adj   = q.q_est - ulp;          // Estimate one too high.
            rem_adj = rem + den_ulp;
        end else if (rem_big) begin
            q_adj   = q.q_est + ulp;          // One too low.
            rem_adj = rem - den_ulp;
        end else begin
            q_adj   = q.q_est;
            rem_adj = rem;
        end
    end

    // In single precision the masked quotient bits sit inside the remainder.
    assign sticky  = |rem_adj;
    assign q.q_fin = {q_adj, sticky};

endmodule

`default_nettype wire

// File: rtl/div_ctrl.sv
`default_nettype none

module div_ctrl (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [fdiv_pkg::MANT_W-1:0] fa,
    input  logic [fdiv_pkg::MANT_W-1:0] fb,
    input  logic                        db,
    input  logic                        fdiv,
    input  logic [7:0]                  seed,
    input  logic [fdiv_pkg::PROD_W-1:0] mul_p,
    output logic [7:0]                  rom_addr,
    output logic [fdiv_pkg::OP_W-1:0]   mul_a,
    output logic [fdiv_pkg::OP_W-1:0]   mul_b,
    output logic [fdiv_pkg::Q_W-1:0]    fq,
    output logic                        done,
    output logic                        busy,
    quot_if.ctrl                        q
);
    import fdiv_pkg::*;

    localparam int GUARD_W = OP_W - MANT_W;
    localparam int QE_W    = Q_W - 1;

    div_state_t               state;
    logic [1:0]               iter_cnt;
    logic [MANT_W-1:0]        fa_r;
    logic [MANT_W-1:0]        fb_r;
    logic                     db_r;
    logic [OP_W-1:0]          recip;      // 1/fb, weight 2^-58.
    logic [OP_W-1:0]          cpl;        // 2 - fb*x, weight 2^-57.
    logic [QE_W-1:0]          q_raw;
    logic [QE_W-1:0]          q_mask;
    logic [QE_W-1:0]          q_est_r;
    logic [MANT_W+QE_W-1:0]   q_b_r;

    assign rom_addr = fb_r[MANT_W-2 -: 8];
    assign busy     = (state != ST_IDLE);

    // fa * x carries 115 fraction bits, keep 55.
    assign q_raw  = mul_p[PROD_W-1 -: QE_W];
    assign q_mask = db_r ? q_raw : {q_raw[QE_W-1:SP_ZERO_W], {SP_ZERO_W{1'b0}}};

    assign q.q_est = q_est_r;
    assign q.q_b   = q_b_r;
    assign q.num   = fa_r;
    assign q.den   = fb_r;
    assign q.sp    = ~db_r;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            iter_cnt <= '0;
            done     <= 1'b0;
            fq       <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (fdiv) begin
                        iter_cnt <= db ? 2'(ITER_DP) : 2'(ITER_SP);
                        state    <= ST_SEED;
                    end
                end
                ST_SEED:    state <= ST_NR_MUL1;
                ST_NR_MUL1: state <= ST_NR_CPL;
                ST_NR_CPL:  state <= ST_NR_MUL2;
                ST_NR_MUL2: state <= ST_NR_UPD;
                ST_NR_UPD: begin
                    iter_cnt <= iter_cnt - 2'd1;
                    state    <= (iter_cnt == 2'd1) ? ST_Q_MUL : ST_NR_MUL1;
                end
                ST_Q_MUL:   state <= ST_Q_EST;
                ST_Q_EST:   state <= ST_Q_CHK;
                ST_Q_CHK:   state <= ST_RESULT;
                ST_RESULT: begin
                    fq    <= q.q_fin;
                    done  <= 1'b1;
                    state <= ST_IDLE;
                end
                default:    state <= ST_IDLE;
            endcase
        end
    end

    // Operands are loaded one state ahead of the state that reads mul_p.
    always_ff @(posedge clk) begin
        case (state)
            ST_IDLE: begin
                if (fdiv) begin
                    fa_r <= fa;
                    fb_r <= fb;
                    db_r <= db;
                end
            end
            ST_SEED:    recip <= {1'b1, seed, {(OP_W-9){1'b0}}};   // 0.1sssssss.
            ST_NR_MUL1: begin
                mul_a <= recip;
                mul_b <= {fb_r, {GUARD_W{1'b0}}};
            end
            // One's complement keeps x at or below 1/fb.
            ST_NR_CPL:  cpl <= ~mul_p[PROD_W-1 -: OP_W];
            ST_NR_MUL2: begin
                mul_a <= cpl;
                mul_b <= recip;
            end
            ST_NR_UPD:  recip <= mul_p[PROD_W-2 -: OP_W];
            ST_Q_MUL: begin
                mul_a <= {fa_r, {GUARD_W{1'b0}}};
                mul_b <= recip;
            end
            ST_Q_EST: begin
                q_est_r <= q_mask;
                mul_a   <= {{(OP_W-QE_W){1'b0}}, q_mask};
                mul_b   <= {{GUARD_W{1'b0}}, fb_r};
            end
            ST_Q_CHK:   q_b_r <= mul_p[MANT_W+QE_W-1:0];   // Exact, 109 bits.
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/fdiv_mant_top.sv
`default_nettype none

module fdiv_mant_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [fdiv_pkg::MANT_W-1:0] fa,
    input  logic [fdiv_pkg::MANT_W-1:0] fb,
    input  logic                        db,
    input  logic                        fdiv,
    output logic [fdiv_pkg::Q_W-1:0]    fq,
    output logic                        done,
    output logic                        busy
);
    import fdiv_pkg::*;

    logic [7:0]        rom_addr;
    logic [7:0]        seed;
    logic [OP_W-1:0]   mul_a;
    logic [OP_W-1:0]   mul_b;
    logic [PROD_W-1:0] mul_p;

    quot_if u_qif ();

    div_ctrl u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .fa       (fa),
        .fb       (fb),
        .db       (db),
        .fdiv     (fdiv),
        .seed     (seed),
        .mul_p    (mul_p),
        .rom_addr (rom_addr),
        .mul_a    (mul_a),
        .mul_b    (mul_b),
        .fq       (fq),
        .done     (done),
        .busy     (busy),
        .q        (u_qif.ctrl)
    );

    recip_rom u_rom (.addr(rom_addr), .data(seed));

    mant_mul u_mul (.a(mul_a), .b(mul_b), .p(mul_p));

    quot_select u_sel (.q(u_qif.sel));

endmodule

`default_nettype wire

// File: bench/div_checker.sv
`default_nettype none

module div_checker (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [fdiv_pkg::MANT_W-1:0] fa,
    input  logic [fdiv_pkg::MANT_W-1:0] fb,
    input  logic                        db,
    input  logic                        fdiv,
    input  logic [fdiv_pkg::Q_W-1:0]    fq,
    input  logic                        done,
    input  logic                        busy,
    input  logic [fdiv_pkg::Q_W-1:0]    exp_fq,
    input  logic                        exp_known,
    output int                          test_cnt,
    output int                          err_cnt
);
    timeunit 1ns;
    timeprecision 100ps;
    import fdiv_pkg::*;

    localparam int NUM_W = MANT_W + Q_W - 2;   // Width of fa * 2^55.

    int                n_tests    = 0;
    int                n_errs     = 0;
    logic              pending    = 1'b0;
    logic              reset_seen = 1'b0;
    logic [MANT_W-1:0] fa_r;
    logic [MANT_W-1:0] fb_r;
    logic              db_r;
    logic [Q_W-1:0]    exp_r;
    logic              known_r;
    logic [Q_W-1:0]    last_fq    = '0;
    logic [Q_W-1:0]    want;
    logic              busy_exp;

    assign test_cnt = n_tests;
    assign err_cnt  = n_errs;

    // Truncated quotient in bits 56:1 and sticky in bit 0.
    function automatic logic [Q_W-1:0] expected_quot(
        input logic [MANT_W-1:0] a,
        input logic [MANT_W-1:0] b,
        input logic              dp
    );
        logic [NUM_W-1:0] num;
        logic [NUM_W-1:0] den;
        logic [NUM_W-1:0] quo;
        logic [Q_W-2:0]   q;
        logic             sticky;
        num    = {a, {(Q_W-2){1'b0}}};
        den    = {{(NUM_W-MANT_W){1'b0}}, b};
        quo    = num / den;
        q      = quo[Q_W-2:0];
        sticky = (num % den) != '0;
        if (!dp) begin
            sticky           = sticky | (|q[SP_ZERO_W-1:0]);   // Dropped bits.
            q[SP_ZERO_W-1:0] = '0;
        end
        return {q, sticky};
    endfunction

    task automatic value_error(
        input string          name,
        input logic [Q_W-1:0] expected,
        input logic [Q_W-1:0] actual
    );
        $display("error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
        n_errs++;
    endtask

    task automatic verify_reset_state();
        if (done !== 1'b0) value_error("done", '0, {{(Q_W-1){1'b0}}, done});
        if (busy !== 1'b0) value_error("busy", '0, {{(Q_W-1){1'b0}}, busy});
        if (fq !== '0)     value_error("fq", '0, fq);
        $display("reset: outputs checked");
    endtask

    task automatic compare_result();
        if (!pending) begin
            $display("error at %0d ns: done pulse with no divide in flight", $time);
            n_errs++;
        end else begin
            want = known_r ? exp_r : expected_quot(fa_r, fb_r, db_r);
            if (fq === want) begin
                $display("test %0d ok: fa=%h fb=%h %s fq=%h",
                         n_tests, fa_r, fb_r, db_r ? "dp" : "sp", fq);
            end else begin
                value_error("fq", want, fq);
            end
            n_tests++;
        end
        pending = 1'b0;
        last_fq = fq;
    endtask

    // Sampled mid-cycle away from the driving edges.
    always @(negedge clk) begin
        if (!rst_n) begin
            pending    = 1'b0;
            reset_seen = 1'b0;
            last_fq    = '0;
        end else begin
            // Busy from the cycle after the start until done.
            busy_exp = pending && !done;
            if (!reset_seen) begin
                verify_reset_state();
                reset_seen = 1'b1;
            end else if (busy !== busy_exp) begin
                value_error("busy", {{(Q_W-1){1'b0}}, busy_exp}, {{(Q_W-1){1'b0}}, busy});
            end
            if (done) begin
                compare_result();
            end else if (fq !== last_fq) begin
                value_error("fq (held)", last_fq, fq);
                last_fq = fq;
            end
            if (fdiv && !busy) begin   // Start taken on the next edge.
                fa_r    = fa;
                fb_r    = fb;
                db_r    = db;
                exp_r   = exp_fq;
                known_r = exp_known;
                pending = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_top.sv
`default_nettype none

module tb_top;
    timeunit 1ns;
    timeprecision 100ps;
    import fdiv_pkg::*;

    localparam int MAX_ROWS = 32;
    localparam int TIMEOUT  = 100;

    localparam logic [MANT_W-1:0] ONE      = 53'h10_0000_0000_0000;
    localparam logic [MANT_W-1:0] ONE_HALF = 53'h18_0000_0000_0000;
    localparam logic [MANT_W-1:0] TWO_ULP  = 53'h1F_FFFF_FFFF_FFFF;   // 2 - ulp.

    logic              clk;
    logic              rst_n;
    logic [MANT_W-1:0] fa;
    logic [MANT_W-1:0] fb;
    logic              db;
    logic              fdiv;
    logic [Q_W-1:0]    fq;
    logic              done;
    logic              busy;

    logic [Q_W-1:0]    exp_fq;
    logic              exp_known;
    int                test_cnt;
    int                err_cnt;

    // Stimulus table. Rows without a known result go to the checker's model.
    logic [MANT_W-1:0] row_fa    [MAX_ROWS];
    logic [MANT_W-1:0] row_fb    [MAX_ROWS];
    logic              row_db    [MAX_ROWS];
    logic [Q_W-1:0]    row_fq    [MAX_ROWS];
    logic              row_known [MAX_ROWS];
    logic              row_extra [MAX_ROWS];   // Second start while busy.
    int                n_rows;
    integer            seed;
    logic              timed_out;

    fdiv_mant_top u_dut (
        .clk   (clk),
        .rst_n (rst_n),
        .fa    (fa),
        .fb    (fb),
        .db    (db),
        .fdiv  (fdiv),
        .fq    (fq),
        .done  (done),
        .busy  (busy)
    );

    div_checker u_chk (
        .clk       (clk),
        .rst_n     (rst_n),
        .fa        (fa),
        .fb        (fb),
        .db        (db),
        .fdiv      (fdiv),
        .fq        (fq),
        .done      (done),
        .busy      (busy),
        .exp_fq    (exp_fq),
        .exp_known (exp_known),
        .test_cnt  (test_cnt),
        .err_cnt   (err_cnt)
    );

    always #2 clk = ~clk;

    task automatic add_row(
        input logic [MANT_W-1:0] a,
        input logic [MANT_W-1:0] b,
        input logic              dp,
        input logic [Q_W-1:0]    q,
        input logic              known,
        input logic              extra
    );
        row_fa[n_rows]    = a;
        row_fb[n_rows]    = b;
        row_db[n_rows]    = dp;
        row_fq[n_rows]    = q;
        row_known[n_rows] = known;
        row_extra[n_rows] = extra;
        n_rows++;
    endtask

    task automatic fill_table();
        logic [63:0] rnd_a;
        logic [63:0] rnd_b;
        // Exact quotients, sticky clear.
        add_row(ONE,      ONE,      1'b1, 57'h100_0000_0000_0000, 1'b1, 1'b0);
        add_row(ONE_HALF, ONE_HALF, 1'b1, 57'h100_0000_0000_0000, 1'b1, 1'b0);
        add_row(TWO_ULP,  ONE,      1'b1, 57'h1FF_FFFF_FFFF_FFF0, 1'b1, 1'b0);
        add_row(ONE_HALF, ONE,      1'b1, 57'h180_0000_0000_0000, 1'b1, 1'b0);
        // 2/3, also hit with a start pulse while busy.
        add_row(ONE,      ONE_HALF, 1'b1, 57'h0AA_AAAA_AAAA_AAAB, 1'b1, 1'b1);
        add_row(ONE,      TWO_ULP,  1'b1, '0, 1'b0, 1'b0);
        // Single precision.
        add_row(ONE,      ONE,      1'b0, 57'h100_0000_0000_0000, 1'b1, 1'b0);
        add_row(ONE,      ONE_HALF, 1'b0, 57'h0AA_AAAA_8000_0001, 1'b1, 1'b0);
        add_row(TWO_ULP,  ONE,      1'b0, 57'h1FF_FFFF_C000_0001, 1'b1, 1'b0);
        // Divisors on either side of a seed table step.
        rnd_a = {$random(seed), $random(seed)};
        add_row({1'b1, rnd_a[51:0]}, {1'b1, 8'h7F, {44{1'b1}}}, 1'b1, '0, 1'b0, 1'b0);
        add_row({1'b1, rnd_a[51:0]}, {1'b1, 8'h80, {44{1'b0}}}, 1'b1, '0, 1'b0, 1'b0);
        add_row({1'b1, rnd_a[51:0]}, {1'b1, 8'hFF, {44{1'b1}}}, 1'b0, '0, 1'b0, 1'b0);
        add_row({1'b1, rnd_a[51:0]}, {1'b1, 8'h00, 44'h1},      1'b1, '0, 1'b0, 1'b0);
        for (int i = 0; i < 12; i++) begin
            rnd_a = {$random(seed), $random(seed)};
            rnd_b = {$random(seed), $random(seed)};
            add_row({1'b1, rnd_a[51:0]}, {1'b1, rnd_b[51:0]}, rnd_a[63], '0, 1'b0, 1'b0);
        end
    endtask

    task automatic run_row(input int idx);
        int cycles;
        @(posedge clk);
        #1;
        fa        = row_fa[idx];
        fb        = row_fb[idx];
        db        = row_db[idx];
        exp_fq    = row_fq[idx];
        exp_known = row_known[idx];
        fdiv      = 1'b1;
        @(posedge clk);
        #1;
        fdiv = 1'b0;
        if (row_extra[idx]) begin
            @(posedge clk);
            #1;
            fa   = {1'b1, ~row_fa[idx][MANT_W-2:0]};   // Must not reach the result.
            fb   = ONE;
            db   = ~row_db[idx];
            fdiv = 1'b1;
            @(posedge clk);
            #1;
            fdiv = 1'b0;
        end
        cycles = 0;
        while (!done && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!done) begin
            $display("test %0d: no result arrived within %0d cycles", idx, TIMEOUT);
            timed_out = 1'b1;
        end
        repeat (4) @(posedge clk);   // Idle gap, fq must hold.
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        fa        = '0;
        fb        = '0;
        db        = 1'b0;
        fdiv      = 1'b0;
        exp_fq    = '0;
        exp_known = 1'b0;
        n_rows    = 0;
        seed      = 32'h3e14_86aa;
        timed_out = 1'b0;
        fill_table();
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < n_rows && !timed_out; i++) begin
            run_row(i);
        end
        $display("%0d rows, %0d results checked, %0d errors", n_rows, test_cnt, err_cnt);
        if (!timed_out && test_cnt != n_rows) begin
            $display("expected %0d results but saw %0d", n_rows, test_cnt);
        end
        if (timed_out || err_cnt != 0 || test_cnt != n_rows) begin
            $display("Test failed");
        end else begin
            $display("Test passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
common/fdiv_pkg.sv
common/quot_if.sv
rtl/recip_rom.sv
rtl/mant_mul.sv
rtl/quot_select.sv
rtl/div_ctrl.sv
rtl/fdiv_mant_top.sv
bench/div_checker.sv
bench/tb_top.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timescale 1ns/100ps -j 0
TOP       = tb_top
FILELIST  = all.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
